/* src/rename_pkg.sv */
// rename stage package: register counts, id widths, queue sizing, control state enum
package rename_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_AREGS = 32;
    localparam int NUM_PREGS = 64;

    localparam int AREG_W = 5;    // arch reg id
    localparam int PREG_W = 6;    // phys reg id

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // group and free list sizing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int RENAME_WIDTH = 2;    // slots per group, also release ports

    // every phys reg beyond the arch set starts out free
    localparam int FREE_DEPTH = NUM_PREGS - NUM_AREGS;

    localparam int COUNT_W = 6;    // holds 0..FREE_DEPTH
    localparam int PTR_W = $clog2(FREE_DEPTH);
    localparam int POP_W = $clog2(RENAME_WIDTH + 1);    // 0..RENAME_WIDTH pops

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic {
        CTRL_INIT,    // filling the free list
        CTRL_RUN      // normal renaming
    } ctrl_state_t;

endpackage

/* src/rat.sv */
// register alias table: identity reset, two write ports, four source reads, old dest readout
`timescale 1ns/1ps

module rat
    import rename_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [RENAME_WIDTH-1:0]                 wr_en,
    input  logic [RENAME_WIDTH-1:0][AREG_W-1:0]     wr_areg,
    input  logic [RENAME_WIDTH-1:0][PREG_W-1:0]     wr_preg,
    input  logic [RENAME_WIDTH-1:0][AREG_W-1:0]     in_src1,
    input  logic [RENAME_WIDTH-1:0][AREG_W-1:0]     in_src2,
    input  logic [RENAME_WIDTH-1:0][AREG_W-1:0]     in_dest,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     rd_psrc1,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     rd_psrc2,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     rd_old_pdest
);

    // arch -> phys mapping
    logic [PREG_W-1:0] map_q [NUM_AREGS];

    // write ports that really update an entry, r0 is fixed
    logic [RENAME_WIDTH-1:0] wr_ok;

    always_comb begin
        for (int w = 0; w < RENAME_WIDTH; w++) begin
            wr_ok[w] = wr_en[w] && (wr_areg[w] != '0);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // table update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map_q[i] <= PREG_W'(i);    // identity map
            end
        end else begin
            // later port assigned last, so it wins on equal ids
            for (int w = 0; w < RENAME_WIDTH; w++) begin
                if (wr_ok[w]) begin
                    map_q[wr_areg[w]] <= wr_preg[w];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reads with forwarding from older slots
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [PREG_W-1:0] table_read(input logic [AREG_W-1:0] areg);
        logic [PREG_W-1:0] preg;
        preg = '0;
        if (areg != '0) begin
            preg = map_q[areg];
        end
        return preg;
    endfunction

    always_comb begin
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            rd_psrc1[s] = table_read(in_src1[s]);
            rd_psrc2[s] = table_read(in_src2[s]);
            rd_old_pdest[s] = table_read(in_dest[s]);

            // youngest older slot checked last
            for (int w = 0; w < s; w++) begin
                if (wr_ok[w] && wr_areg[w] == in_src1[s]) begin
                    rd_psrc1[s] = wr_preg[w];
                end
                if (wr_ok[w] && wr_areg[w] == in_src2[s]) begin
                    rd_psrc2[s] = wr_preg[w];
                end
                if (wr_ok[w] && wr_areg[w] == in_dest[s]) begin
                    rd_old_pdest[s] = wr_preg[w];    // waw inside the group
                end
            end
        end
    end

endmodule

/* src/free_list.sv */
// circular queue of free phys reg ids with two pops and two pushes per cycle
`timescale 1ns/1ps

module free_list
    import rename_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [POP_W-1:0]                        pop_count,
    input  logic [RENAME_WIDTH-1:0]                 push_en,
    input  logic [RENAME_WIDTH-1:0][PREG_W-1:0]     push_preg,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     free_head,
    output logic [COUNT_W-1:0]                      free_count
);

    logic [PREG_W-1:0] mem [FREE_DEPTH];    // queue storage

    logic [PTR_W-1:0]   head_q;
    logic [PTR_W-1:0]   tail_q;
    logic [COUNT_W-1:0] count_q;

    logic [RENAME_WIDTH-1:0][PTR_W-1:0] push_addr;
    logic [POP_W-1:0]                   push_num;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // push slot allocation with port 0 first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        push_num = '0;
        for (int p = 0; p < RENAME_WIDTH; p++) begin
            push_addr[p] = tail_q + PTR_W'(push_num);
            if (push_en[p]) begin
                push_num = push_num + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < RENAME_WIDTH; p++) begin
            if (push_en[p]) begin
                mem[push_addr[p]] <= push_preg[p];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;    // empty until the fill
        end else begin
            head_q  <= head_q + PTR_W'(pop_count);
            tail_q  <= tail_q + PTR_W'(push_num);
            count_q <= count_q - COUNT_W'(pop_count) + COUNT_W'(push_num);
        end
    end

    // two oldest entries with the pointer wrapping at the queue depth
    always_comb begin
        for (int h = 0; h < RENAME_WIDTH; h++) begin
            free_head[h] = mem[head_q + PTR_W'(h)];
        end
    end

    assign free_count = count_q;

endmodule

/* src/rename_ctrl.sv */
// rename control: init fill fsm, accept decision, free reg steering, output registers
`timescale 1ns/1ps

module rename_ctrl
    import rename_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [RENAME_WIDTH-1:0]                 in_valid,
    input  logic [RENAME_WIDTH-1:0][AREG_W-1:0]     in_dest,
    input  logic [RENAME_WIDTH-1:0]                 rel_valid,
    input  logic [RENAME_WIDTH-1:0][PREG_W-1:0]     rel_preg,
    input  logic [RENAME_WIDTH-1:0][PREG_W-1:0]     free_head,
    input  logic [COUNT_W-1:0]                      free_count,
    input  logic [RENAME_WIDTH-1:0][PREG_W-1:0]     rd_psrc1,
    input  logic [RENAME_WIDTH-1:0][PREG_W-1:0]     rd_psrc2,
    input  logic [RENAME_WIDTH-1:0][PREG_W-1:0]     rd_old_pdest,
    output logic                                    ready,
    output logic                                    accept,
    output logic [RENAME_WIDTH-1:0]                 out_valid,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_psrc1,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_psrc2,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_pdest,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_old_pdest,
    output logic [RENAME_WIDTH-1:0]                 wr_en,
    output logic [RENAME_WIDTH-1:0][AREG_W-1:0]     wr_areg,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     wr_preg,
    output logic [POP_W-1:0]                        pop_count,
    output logic [RENAME_WIDTH-1:0]                 push_en,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     push_preg
);

    ctrl_state_t       state_q;
    logic [PREG_W-1:0] fill_q;    // next phys reg to hand to the free list

    logic [RENAME_WIDTH-1:0] need;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // init fill, one reg per cycle from NUM_AREGS up
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= CTRL_INIT;
            fill_q  <= PREG_W'(NUM_AREGS);
        end else if (state_q == CTRL_INIT) begin
            fill_q <= fill_q + 1'b1;
            if (fill_q == PREG_W'(NUM_PREGS - 1)) begin
                state_q <= CTRL_RUN;    // last reg pushed this edge
            end
        end
    end

    always_comb begin
        if (state_q == CTRL_INIT) begin
            push_en      = '0;
            push_en[0]   = 1'b1;
            push_preg    = '0;
            push_preg[0] = fill_q;
        end else begin
            push_en   = rel_valid;    // commit releases pass straight through
            push_preg = rel_preg;
        end
    end

    assign ready  = (state_q == CTRL_RUN);
    assign accept = ready && (free_count >= COUNT_W'(RENAME_WIDTH));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // steering: each needing slot takes the next unused head
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        pop_count = '0;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            need[s]    = accept && in_valid[s] && (in_dest[s] != '0);
            wr_areg[s] = in_dest[s];
            wr_preg[s] = free_head[pop_count];
            if (need[s]) begin
                pop_count = pop_count + 1'b1;
            end
        end
    end

    assign wr_en = need;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= '0;
        end else begin
            out_valid <= accept ? in_valid : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int s = 0; s < RENAME_WIDTH; s++) begin
                out_psrc1[s] <= rd_psrc1[s];
                out_psrc2[s] <= rd_psrc2[s];
                // r0 dest keeps both ids at 0
                out_pdest[s]     <= need[s] ? wr_preg[s] : '0;
                out_old_pdest[s] <= need[s] ? rd_old_pdest[s] : '0;
            end
        end
    end

endmodule

/* src/rename_top.sv */
// rename stage top: control, alias table and free list
`timescale 1ns/1ps

module rename_top
    import rename_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [RENAME_WIDTH-1:0]                 in_valid,
    input  logic [RENAME_WIDTH-1:0][AREG_W-1:0]     in_dest,
    input  logic [RENAME_WIDTH-1:0][AREG_W-1:0]     in_src1,
    input  logic [RENAME_WIDTH-1:0][AREG_W-1:0]     in_src2,
    input  logic [RENAME_WIDTH-1:0]                 rel_valid,
    input  logic [RENAME_WIDTH-1:0][PREG_W-1:0]     rel_preg,
    output logic                                    ready,
    output logic                                    accept,
    output logic [RENAME_WIDTH-1:0]                 out_valid,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_psrc1,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_psrc2,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_pdest,
    output logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_old_pdest
);

    // table write ports
    logic [RENAME_WIDTH-1:0]             wr_en;
    logic [RENAME_WIDTH-1:0][AREG_W-1:0] wr_areg;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0] wr_preg;

    // table read data
    logic [RENAME_WIDTH-1:0][PREG_W-1:0] rd_psrc1;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0] rd_psrc2;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0] rd_old_pdest;

    // free list side
    logic [RENAME_WIDTH-1:0][PREG_W-1:0] free_head;
    logic [COUNT_W-1:0]                  free_count;
    logic [POP_W-1:0]                    pop_count;
    logic [RENAME_WIDTH-1:0]             push_en;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0] push_preg;

    rename_ctrl i_rename_ctrl (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_dest       (in_dest),
        .rel_valid     (rel_valid),
        .rel_preg      (rel_preg),
        .free_head     (free_head),
        .free_count    (free_count),
        .rd_psrc1      (rd_psrc1),
        .rd_psrc2      (rd_psrc2),
        .rd_old_pdest  (rd_old_pdest),
        .ready         (ready),
        .accept        (accept),
        .out_valid     (out_valid),
        .out_psrc1     (out_psrc1),
        .out_psrc2     (out_psrc2),
        .out_pdest     (out_pdest),
        .out_old_pdest (out_old_pdest),
        .wr_en         (wr_en),
        .wr_areg       (wr_areg),
        .wr_preg       (wr_preg),
        .pop_count     (pop_count),
        .push_en       (push_en),
        .push_preg     (push_preg)
    );

    rat i_rat (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_areg      (wr_areg),
        .wr_preg      (wr_preg),
        .in_src1      (in_src1),
        .in_src2      (in_src2),
        .in_dest      (in_dest),
        .rd_psrc1     (rd_psrc1),
        .rd_psrc2     (rd_psrc2),
        .rd_old_pdest (rd_old_pdest)
    );

    free_list i_free_list (
        .clk        (clk),
        .reset      (reset),
        .pop_count  (pop_count),
        .push_en    (push_en),
        .push_preg  (push_preg),
        .free_head  (free_head),
        .free_count (free_count)
    );

endmodule

/* tests/rename_asserts.sv */
// bound concurrent assertions for reset outputs, free count bound and pdest sanity
`timescale 1ns/1ps

module rename_asserts
    import rename_pkg::*;
(
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 accept,
    input logic [RENAME_WIDTH-1:0]              in_valid,
    input logic [RENAME_WIDTH-1:0][AREG_W-1:0]  in_dest,
    input logic [RENAME_WIDTH-1:0]              out_valid,
    input logic [RENAME_WIDTH-1:0][PREG_W-1:0]  out_pdest,
    input logic [COUNT_W-1:0]                   free_count
);

    int error_count = 0;    // failed assertions so far

    // nothing leaves the stage right after a reset cycle
    a_reset_quiet: assert property (@(posedge clk) reset |=> out_valid == '0)
        else begin
            $error("out_valid high in the cycle after reset");
            error_count++;
        end

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        free_count <= COUNT_W'(FREE_DEPTH))
        else begin
            $error("free_count above free list depth");
            error_count++;
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // allocated ids
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_pdest_distinct: assert property (@(posedge clk) disable iff (reset)
        accept && (&in_valid) && in_dest[0] != '0 && in_dest[1] != '0
        |=> out_pdest[0] != out_pdest[1])
        else begin
            $error("both slots got the same pdest");
            error_count++;
        end

    a_pdest0_nonzero: assert property (@(posedge clk) disable iff (reset)
        accept && in_valid[0] && in_dest[0] != '0 |=> out_pdest[0] != '0)
        else begin
            $error("slot 0 renamed onto preg 0");
            error_count++;
        end

    a_pdest1_nonzero: assert property (@(posedge clk) disable iff (reset)
        accept && in_valid[1] && in_dest[1] != '0 |=> out_pdest[1] != '0)
        else begin
            $error("slot 1 renamed onto preg 0");
            error_count++;
        end

endmodule

/* tests/rename_tb.sv */
// rename testbench with clock, reset, vector file reader, stimulus and output checks
`timescale 1ns/1ps

module rename_tb
    import rename_pkg::*;
();

    logic                                    clk;
    logic                                    reset;
    logic [RENAME_WIDTH-1:0]                 in_valid;
    logic [RENAME_WIDTH-1:0][AREG_W-1:0]     in_dest;
    logic [RENAME_WIDTH-1:0][AREG_W-1:0]     in_src1;
    logic [RENAME_WIDTH-1:0][AREG_W-1:0]     in_src2;
    logic [RENAME_WIDTH-1:0]                 rel_valid;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0]     rel_preg;
    logic                                    ready;
    logic                                    accept;
    logic [RENAME_WIDTH-1:0]                 out_valid;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_psrc1;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_psrc2;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_pdest;
    logic [RENAME_WIDTH-1:0][PREG_W-1:0]     out_old_pdest;

    int vec [64][23];    // one row per cycle with the vector file's columns
    int num_rows;

    bind rename_top rename_asserts i_rename_asserts (.*);

    rename_top i_rename_top (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_dest       (in_dest),
        .in_src1       (in_src1),
        .in_src2       (in_src2),
        .rel_valid     (rel_valid),
        .rel_preg      (rel_preg),
        .ready         (ready),
        .accept        (accept),
        .out_valid     (out_valid),
        .out_psrc1     (out_psrc1),
        .out_psrc2     (out_psrc2),
        .out_pdest     (out_pdest),
        .out_old_pdest (out_old_pdest)
    );

    always #20 clk = ~clk;    // 40 ns period

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input int exp, input logic [31:0] act);
        assert (act === 32'(exp)) else begin
            stop_with_failure($sformatf("[FAIL] time %0t %s expected %0d actual %0d",
                                        $time, name, exp, act));
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        fd = $fopen("tests/rename_input.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open tests/rename_input.txt");
        end
        num_rows = 0;
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line,
                "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                vec[num_rows][0], vec[num_rows][1], vec[num_rows][2], vec[num_rows][3],
                vec[num_rows][4], vec[num_rows][5], vec[num_rows][6], vec[num_rows][7],
                vec[num_rows][8], vec[num_rows][9], vec[num_rows][10], vec[num_rows][11],
                vec[num_rows][12], vec[num_rows][13], vec[num_rows][14], vec[num_rows][15],
                vec[num_rows][16], vec[num_rows][17], vec[num_rows][18], vec[num_rows][19],
                vec[num_rows][20], vec[num_rows][21], vec[num_rows][22]);
            if (n == 23) begin
                num_rows++;
                if (num_rows == 64) begin
                    stop_with_failure("vector file has more rows than the table holds");
                end
            end else if (n > 0) begin
                stop_with_failure($sformatf("vector line has wrong column count: %s", line));
            end
        end
        $fclose(fd);
        if (num_rows == 0) begin
            stop_with_failure("vector file holds no vector rows");
        end
    endtask

    // stimulus on the rising edge
    task automatic drive_row(input int r);
        logic [RENAME_WIDTH-1:0]             v;
        logic [RENAME_WIDTH-1:0][AREG_W-1:0] d;
        logic [RENAME_WIDTH-1:0][AREG_W-1:0] a;
        logic [RENAME_WIDTH-1:0][AREG_W-1:0] b;
        logic [RENAME_WIDTH-1:0]             rv;
        logic [RENAME_WIDTH-1:0][PREG_W-1:0] rp;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            v[s]  = (vec[r][4 * s] != 0);
            d[s]  = AREG_W'(vec[r][4 * s + 1]);
            a[s]  = AREG_W'(vec[r][4 * s + 2]);
            b[s]  = AREG_W'(vec[r][4 * s + 3]);
            rv[s] = (vec[r][8 + 2 * s] != 0);
            rp[s] = PREG_W'(vec[r][9 + 2 * s]);
        end
        in_valid  <= v;
        in_dest   <= d;
        in_src1   <= a;
        in_src2   <= b;
        rel_valid <= rv;
        rel_preg  <= rp;
    endtask

    task automatic drive_idle();
        in_valid  <= '0;
        rel_valid <= '0;
    endtask

    // ids only matter for a valid slot
    task automatic check_outputs(input int r);
        int base;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
            base = 13 + 5 * s;
            check_value($sformatf("out_valid[%0d]", s), vec[r][base], out_valid[s]);
            if (vec[r][base] != 0) begin
                check_value($sformatf("out_psrc1[%0d]", s), vec[r][base + 1], out_psrc1[s]);
                check_value($sformatf("out_psrc2[%0d]", s), vec[r][base + 2], out_psrc2[s]);
                check_value($sformatf("out_pdest[%0d]", s), vec[r][base + 3], out_pdest[s]);
                check_value($sformatf("out_old_pdest[%0d]", s), vec[r][base + 4],
                            out_old_pdest[s]);
            end
        end
    endtask

    always @(negedge clk) begin
        if (i_rename_top.i_rename_asserts.error_count != 0) begin
            stop_with_failure("a concurrent assertion in rename_asserts failed");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int cycles;
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = '0;
        in_dest   = '0;
        in_src1   = '0;
        in_src2   = '0;
        rel_valid = '0;
        rel_preg  = '0;
        load_vectors();

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("ready", 0, ready);
        check_value("accept", 0, accept);
        check_value("out_valid", 0, out_valid);
        @(posedge clk);
        reset <= 1'b0;    // fourth reset edge

        // wait out the free list fill
        for (cycles = 1; cycles <= 100; cycles++) begin
            @(negedge clk);
            if (ready) begin
                break;
            end
            check_value("accept", 0, accept);
            check_value("out_valid", 0, out_valid);
        end
        if (cycles > 100) begin
            stop_with_failure("ready did not rise within 100 cycles of reset release");
        end
        assert (cycles == 33) else begin
            stop_with_failure($sformatf("ready rose in cycle %0d after reset release, not 33",
                                        cycles));
        end

        for (int r = 0; r < num_rows; r++) begin
            @(posedge clk);
            drive_row(r);
            @(negedge clk);
            check_value("accept", vec[r][12], accept);
            if (r > 0) begin
                check_outputs(r - 1);    // group from the previous row
            end
        end
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check_outputs(num_rows - 1);

        if (i_rename_top.i_rename_asserts.error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure("a concurrent assertion in rename_asserts failed");
        end
    end

endmodule

/* list.f */
src/rename_pkg.sv
src/rat.sv
src/free_list.sv
src/rename_ctrl.sv
src/rename_top.sv
tests/rename_asserts.sv
tests/rename_tb.sv

/* tests/rename_input.txt */
# v0 d0 s1_0 s2_0 v1 d1 s1_1 s2_1 relv0 relp0 relv1 relp1 accept (stimulus, accept this cycle)
# ov0 ps1_0 ps2_0 pd0 opd0 ov1 ps1_1 ps2_1 pd1 opd1 (outputs expected one cycle later)
1  1  2  3 1  4  5  6 0  0 0  0 1 1  2  3 32  1 1  5  6 33  4
1  7  1  4 1  8  7  1 0  0 0  0 1 1 32 33 34  7 1 34 32 35  8
1  9  2  3 1  9  9  8 0  0 0  0 1 1  2  3 36  9 1 36 35 37 36
1 10  9  0 1  0 10  0 0  0 0  0 1 1 37  0 38 10 1 38  0  0  0
1  0  1  2 1 11  0  4 0  0 0  0 1 1 32  2  0  0 1  0 33 39 11
1 12 11 10 0 13  1  2 0  0 0  0 1 1 39 38 40 12 0  0  0  0  0
0  0  0  0 0  0  0  0 0  0 0  0 1 0  0  0  0  0 0  0  0  0  0
0  5  1  2 1 13 12  1 0  0 0  0 1 0  0  0  0  0 1 40 32 41 13
1 14 14  1 1 24 14  2 0  0 0  0 1 1 14 32 42 14 1 42  2 43 24
1 15 15  1 1 25 15  2 0  0 0  0 1 1 15 32 44 15 1 44  2 45 25
1 16 16  1 1 26 16  2 0  0 0  0 1 1 16 32 46 16 1 46  2 47 26
1 17 17  1 1 27 17  2 0  0 0  0 1 1 17 32 48 17 1 48  2 49 27
1 18 18  1 1 28 18  2 0  0 0  0 1 1 18 32 50 18 1 50  2 51 28
1 19 19  1 1 29 19  2 0  0 0  0 1 1 19 32 52 19 1 52  2 53 29
1 20 20  1 1 30 20  2 0  0 0  0 1 1 20 32 54 20 1 54  2 55 30
1 21 21  1 1 31 21  2 0  0 0  0 1 1 21 32 56 21 1 56  2 57 31
1 22 22  1 1  1 22  2 0  0 0  0 1 1 22 32 58 22 1 58  2 59 32
1 23 23  1 1  4 23  2 0  0 0  0 1 1 23 59 60 23 1 60  2 61 33
1  5  4  7 0  0  0  0 0  0 0  0 1 1 61 34 62  5 0  0  0  0  0
1  6  1  5 1  3  6  0 0  0 0  0 0 0  0  0  0  0 0  0  0  0  0
1  6  1  5 1  3  6  0 1  1 1  4 0 0  0  0  0  0 0  0  0  0  0
1  6  1  5 1  3  6  0 1  7 0  0 1 1 59 62 63  6 1 63  0  1  3
1  2  3  6 1  2  2  2 1  8 1 36 1 1  1 63  4  2 1  4  4  7  4
1  0  2  3 1 14  2  0 0  0 0  0 1 1  7  1  0  0 1  7  0  8 42
1 15 14 15 1 16 15 14 0  0 1 10 0 0  0  0  0  0 0  0  0  0  0
1 15 14 15 1 16 15 14 0  0 0  0 1 1  8 44 36 44 1 36  8 10 46
0  0  0  0 0  0  0  0 1 11 1 12 0 0  0  0  0  0 0  0  0  0  0
1 17 16  0 1 18 17 17 0  0 0  0 1 1 10  0 11 48 1 11 11 12 50
0  0  0  0 0  0  0  0 1 13 1  5 0 0  0  0  0  0 0  0  0  0  0
0  0  0  0 0  0  0  0 1  6 0  0 1 0  0  0  0  0 0  0  0  0  0
1 19 18 16 1 20 19 19 0  0 0  0 1 1 12 10 13 52 1 13 13  5 54
0  0  0  0 0  0  0  0 0  0 0  0 0 0  0  0  0  0 0  0  0  0  0
